// ==== list.f ====
source/ntt_pwm_pkg.sv
source/pwm_operand_if.sv
source/mod_q_reduce.sv
source/masked_mult.sv
source/masked_add.sv
source/delay_line.sv
source/rnd_gen.sv
source/ntt_masked_pairwm.sv
source/ntt_masked_pwm_top.sv
test/tb_ntt_masked_pwm.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, fail when the log reports failure
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f list.f --top-module tb_ntt_masked_pwm -o sim_pwm
./obj_dir/sim_pwm > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== test/tb_ntt_masked_pwm.sv ====
/*
 * directed testbench for the masked pairwise-multiply engine,
 * results are unmasked and compared with a model on plain coefficients
 */
`timescale 1ns/1ns
`default_nettype none

module tb_ntt_masked_pwm;

    localparam int Q = 3329;
    localparam int LATENCY = 10;
    localparam int MAX_CYCLES = 2000;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic in_valid;
    logic accumulate;
    ntt_pwm_pkg::masked_coeff_t u0, u1, v0, v1, w0, w1, zeta;
    ntt_pwm_pkg::masked_coeff_t res0, res1;
    logic out_valid;

    int cycle = 0;
    int errors = 0;
    int results = 0;
    int last_c0 = 0;
    int last_c1 = 0;
    int single_c0 = 0;
    int single_c1 = 0;
    // expected results in order, with the cycle their pair was visible
    int exp_stamp[$];
    int exp_c0[$];
    int exp_c1[$];

    ntt_masked_pwm_top ntt_masked_pwm_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        while (cycle < MAX_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", cycle);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("FAILED at %0t ns: %s expected %0d, actual %0d", $time, name, expected,
                 actual);
    endtask

    task automatic report_problem(input string text);
        errors++;
        $display("error at %0t ns: %s", $time, text);
    endtask

    function automatic int unmask(input ntt_pwm_pkg::masked_coeff_t m);
        return (int'(m[0]) + int'(m[1])) % Q;
    endfunction

    function automatic ntt_pwm_pkg::masked_coeff_t make_shares(input int s0, input int s1);
        return {12'(s1), 12'(s0)};
    endfunction

    function automatic ntt_pwm_pkg::masked_coeff_t split_random(input int value);
        int s0;
        s0 = int'($urandom % Q);
        return make_shares(s0, (value + Q - s0) % Q);
    endfunction

    // product modulo X^2 - zeta on plain coefficients
    function automatic int model_c0(input int a0, a1, b0, b1, z);
        return (a0 * b0 % Q + (a1 * b1 % Q) * z % Q) % Q;
    endfunction

    function automatic int model_c1(input int a0, a1, b0, b1);
        return (a0 * b1 + a1 * b0) % Q;
    endfunction

    // --------------------
    // reference model and output monitor, sampled mid-cycle
    always @(negedge clk) begin
        int c0;
        int c1;
        if (out_valid) begin
            results++;
            last_c0 = unmask(res0);
            last_c1 = unmask(res1);
            if (exp_stamp.size() == 0) begin
                report_problem("out_valid high with no pair pending");
            end else begin
                if (cycle != exp_stamp[0] + LATENCY)
                    report_mismatch("out_valid latency", LATENCY, cycle - exp_stamp[0]);
                if (last_c0 != exp_c0[0]) report_mismatch("res0", exp_c0[0], last_c0);
                if (last_c1 != exp_c1[0]) report_mismatch("res1", exp_c1[0], last_c1);
                void'(exp_stamp.pop_front());
                void'(exp_c0.pop_front());
                void'(exp_c1.pop_front());
            end
        end else if (exp_stamp.size() != 0 && cycle >= exp_stamp[0] + LATENCY) begin
            report_problem("result missing, out_valid stayed low");
            void'(exp_stamp.pop_front());
            void'(exp_c0.pop_front());
            void'(exp_c1.pop_front());
        end
        if (!reset_n || zeroize) begin
            // the clear drops every pair in flight, this one too
            exp_stamp.delete();
            exp_c0.delete();
            exp_c1.delete();
        end else if (in_valid) begin
            c0 = model_c0(unmask(u0), unmask(u1), unmask(v0), unmask(v1), unmask(zeta));
            c1 = model_c1(unmask(u0), unmask(u1), unmask(v0), unmask(v1));
            if (accumulate) begin
                c0 = (c0 + unmask(w0)) % Q;
                c1 = (c1 + unmask(w1)) % Q;
            end
            exp_stamp.push_back(cycle);
            exp_c0.push_back(c0);
            exp_c1.push_back(c1);
        end
    end

    // --------------------
    // drivers
    task automatic send_pair(input ntt_pwm_pkg::masked_coeff_t a0, a1, b0, b1, z, wa, wb,
                             input logic acc);
        @(posedge clk);
        in_valid <= 1'b1;
        accumulate <= acc;
        u0 <= a0;
        u1 <= a1;
        v0 <= b0;
        v1 <= b1;
        zeta <= z;
        w0 <= wa;
        w1 <= wb;
    endtask

    task automatic send_values(input int a0, a1, b0, b1, z, wa, wb, input logic acc);
        send_pair(split_random(a0), split_random(a1), split_random(b0), split_random(b1),
                  split_random(z), split_random(wa), split_random(wb), acc);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
        accumulate <= 1'b0;
    endtask

    task automatic wait_drain();
        drive_idle();
        while (exp_stamp.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic expect_result_count(input int start, input int count);
        if (results - start != count) report_mismatch("result count", count, results - start);
    endtask

    // --------------------
    // tests
    task automatic apply_reset_and_check();
        for (int i = 1; i <= 7; i++) begin
            @(posedge clk);
            if (i == 4) reset_n <= 1'b1;
            @(negedge clk);
            if (out_valid !== 1'b0) report_mismatch("out_valid", 0, int'(out_valid));
            if (res0 !== '0) report_mismatch("res0 shares", 0, int'(res0));
            if (res1 !== '0) report_mismatch("res1 shares", 0, int'(res1));
        end
    endtask

    task automatic run_single_pair();
        int start;
        start = results;
        single_c0 = model_c0(1234, 567, 2890, 45, 17);
        single_c1 = model_c1(1234, 567, 2890, 45);
        send_values(1234, 567, 2890, 45, 17, 100, 3000, 1'b0);
        wait_drain();
        expect_result_count(start, 1);
        if (last_c0 != single_c0) report_mismatch("res0", single_c0, last_c0);
        if (last_c1 != single_c1) report_mismatch("res1", single_c1, last_c1);
    endtask

    task automatic run_accumulate();
        send_values(1234, 567, 2890, 45, 17, 100, 3000, 1'b1);
        wait_drain();
        if (last_c0 != (single_c0 + 100) % Q)
            report_mismatch("res0", (single_c0 + 100) % Q, last_c0);
        if (last_c1 != (single_c1 + 3000) % Q)
            report_mismatch("res1", (single_c1 + 3000) % Q, last_c1);
        // w is ignored while accumulate is low
        send_values(1234, 567, 2890, 45, 17, 100, 3000, 1'b0);
        wait_drain();
        if (last_c0 != single_c0) report_mismatch("res0", single_c0, last_c0);
        if (last_c1 != single_c1) report_mismatch("res1", single_c1, last_c1);
    endtask

    task automatic stream_random_pairs();
        int start;
        start = results;
        for (int i = 0; i < 200; i++) begin
            send_values(int'($urandom % Q), int'($urandom % Q), int'($urandom % Q),
                        int'($urandom % Q), int'($urandom % Q), int'($urandom % Q),
                        int'($urandom % Q), 1'($urandom & 1));
        end
        wait_drain();
        expect_result_count(start, 200);
    endtask

    task automatic send_edge_values();
        ntt_pwm_pkg::masked_coeff_t top;
        ntt_pwm_pkg::masked_coeff_t wrap_zero;
        ntt_pwm_pkg::masked_coeff_t flat_zero;
        int start;
        top = make_shares(Q - 1, 0);
        wrap_zero = make_shares(Q - 1, 1);
        flat_zero = make_shares(0, 0);
        start = results;
        send_pair(top, top, top, top, top, top, top, 1'b0);
        send_pair(top, top, top, top, top, top, top, 1'b1);
        send_pair(make_shares(0, Q - 1), top, top, make_shares(0, Q - 1), top, top,
                  make_shares(0, Q - 1), 1'b1);
        send_pair(wrap_zero, wrap_zero, wrap_zero, wrap_zero, top, wrap_zero, wrap_zero, 1'b1);
        send_pair(flat_zero, flat_zero, flat_zero, flat_zero, flat_zero, flat_zero, flat_zero,
                  1'b1);
        wait_drain();
        expect_result_count(start, 5);
    endtask

    task automatic zeroize_in_flight();
        int start;
        start = results;
        for (int i = 0; i < 5; i++) begin
            send_values(int'($urandom % Q), 17, int'($urandom % Q), 300, 17, 5, 6, 1'b1);
        end
        send_values(1, 2, 3, 4, 17, 5, 6, 1'b0);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        in_valid <= 1'b0;
        @(negedge clk);
        if (res0 !== '0) report_mismatch("res0 shares", 0, int'(res0));
        if (res1 !== '0) report_mismatch("res1 shares", 0, int'(res1));
        for (int i = 0; i < 14; i++) begin
            if (out_valid !== 1'b0) report_mismatch("out_valid", 0, int'(out_valid));
            @(negedge clk);
        end
        expect_result_count(start, 0);
        send_values(1234, 567, 2890, 45, 17, 100, 3000, 1'b1);
        wait_drain();
        expect_result_count(start, 1);
    endtask

    initial begin
        reset_n = 1'b0;
        zeroize = 1'b0;
        in_valid = 1'b0;
        accumulate = 1'b0;
        {u0, u1, v0, v1, w0, w1, zeta} = '0;
        void'($urandom(32'h7f48804f));
        apply_reset_and_check();
        run_single_pair();
        run_accumulate();
        stream_random_pairs();
        send_edge_values();
        zeroize_in_flight();
        $display("results received: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/ntt_masked_pwm_top.sv ====
/*
 * masked pairwise-multiply engine with its refresh generator, plain ports
 */
`timescale 1ns/1ns
`default_nettype none

module ntt_masked_pwm_top #(
    parameter logic [63:0] LFSR_SEED = 64'h5a3c_96e1_0f2d_b487
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       in_valid,
    input  logic                       accumulate,
    input  ntt_pwm_pkg::masked_coeff_t u0,
    input  ntt_pwm_pkg::masked_coeff_t u1,
    input  ntt_pwm_pkg::masked_coeff_t v0,
    input  ntt_pwm_pkg::masked_coeff_t v1,
    input  ntt_pwm_pkg::masked_coeff_t w0,
    input  ntt_pwm_pkg::masked_coeff_t w1,
    input  ntt_pwm_pkg::masked_coeff_t zeta,
    output ntt_pwm_pkg::masked_coeff_t res0,
    output ntt_pwm_pkg::masked_coeff_t res1,
    output logic                       out_valid
);

    pwm_operand_if op_if ();

    ntt_pwm_pkg::rnd_words_t rnd;

    // operand bundle
    assign op_if.valid = in_valid;
    assign op_if.accumulate = accumulate;
    assign op_if.u0 = u0;
    assign op_if.u1 = u1;
    assign op_if.v0 = v0;
    assign op_if.v1 = v1;
    assign op_if.w0 = w0;
    assign op_if.w1 = w1;
    assign op_if.zeta = zeta;

    rnd_gen #(
        .LFSR_SEED (LFSR_SEED)
    ) rnd_gen_i (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .rnd     (rnd)
    );

    ntt_masked_pairwm pairwm_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .op        (op_if),
        .rnd       (rnd),
        .res0      (res0),
        .res1      (res1),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== source/ntt_masked_pairwm.sv ====
/*
 * masked pairwise multiply-accumulate, c0 = u0 v0 + u1 v1 zeta and c1 = u0 v1 + u1 v0
 * plus optional w, all in two arithmetic shares mod q
 */
`timescale 1ns/1ns
`default_nettype none

module ntt_masked_pairwm (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    pwm_operand_if.sink                op,
    input  ntt_pwm_pkg::rnd_words_t    rnd,
    output ntt_pwm_pkg::masked_coeff_t res0,
    output ntt_pwm_pkg::masked_coeff_t res1,
    output logic                       out_valid
);

    typedef ntt_pwm_pkg::masked_coeff_t [2:0] prod_trio_t;

    typedef struct packed {
        logic                       accumulate;
        ntt_pwm_pkg::masked_coeff_t w0;
        ntt_pwm_pkg::masked_coeff_t w1;
    } acc_op_t;

    ntt_pwm_pkg::masked_coeff_t u0v0, u0v1, u1v0, zeta_v1;
    ntt_pwm_pkg::masked_coeff_t u1_d, u1_zv1;
    ntt_pwm_pkg::masked_coeff_t c0, c1;
    ntt_pwm_pkg::masked_coeff_t w0_sel, w1_sel;
    prod_trio_t                 prod_in, prod_d;
    acc_op_t                    acc_in, acc_d;

    // --------------------
    // first multiplier stage, four independent products
    masked_mult mult_u0v0_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(op.u0), .y(op.v0), .r(rnd[0]), .z(u0v0)
    );

    masked_mult mult_u0v1_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(op.u0), .y(op.v1), .r(rnd[1]), .z(u0v1)
    );

    masked_mult mult_u1v0_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(op.u1), .y(op.v0), .r(rnd[2]), .z(u1v0)
    );

    masked_mult mult_zeta_v1_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(op.zeta), .y(op.v1), .r(rnd[3]), .z(zeta_v1)
    );

    // u1 waits for zeta*v1 to come out of its multiplier
    delay_line #(.payload_t(ntt_pwm_pkg::masked_coeff_t), .DEPTH(ntt_pwm_pkg::MULT_LAT))
        u1_delay_i (.clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(op.u1), .q(u1_d));

    // --------------------
    // second multiplier stage
    masked_mult mult_u1_zv1_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(u1_d), .y(zeta_v1), .r(rnd[4]), .z(u1_zv1)
    );

    assign prod_in = {u0v0, u0v1, u1v0};

    delay_line #(.payload_t(prod_trio_t), .DEPTH(ntt_pwm_pkg::MULT_LAT))
        prod_delay_i (.clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(prod_in), .q(prod_d));

    // --------------------
    // coefficient adders
    masked_add add_c0_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(prod_d[2]), .y(u1_zv1), .s(c0)
    );

    masked_add add_c1_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(prod_d[1]), .y(prod_d[0]), .s(c1)
    );

    // w rides alongside until the accumulation stage
    always_comb begin
        acc_in.accumulate = op.accumulate;
        acc_in.w0 = op.w0;
        acc_in.w1 = op.w1;
    end

    delay_line #(.payload_t(acc_op_t), .DEPTH(2 * ntt_pwm_pkg::MULT_LAT + ntt_pwm_pkg::ADD_LAT))
        acc_delay_i (.clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(acc_in), .q(acc_d));

    // a zero pair leaves the product unchanged
    assign w0_sel = acc_d.accumulate ? acc_d.w0 : '0;
    assign w1_sel = acc_d.accumulate ? acc_d.w1 : '0;

    masked_add add_acc0_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(c0), .y(w0_sel), .s(res0)
    );

    masked_add add_acc1_i (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(c1), .y(w1_sel), .s(res1)
    );

    delay_line #(.payload_t(logic), .DEPTH(ntt_pwm_pkg::PWM_LAT))
        valid_delay_i (.clk(clk), .reset_n(reset_n), .zeroize(zeroize), .d(op.valid),
                       .q(out_valid));

endmodule

`default_nettype wire

// ==== source/rnd_gen.sv ====
/*
 * LFSR stand-in for the entropy source, five refresh words below q per cycle
 */
`timescale 1ns/1ns
`default_nettype none

module rnd_gen #(
    parameter logic [63:0] LFSR_SEED = 64'h5a3c_96e1_0f2d_b487
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    output ntt_pwm_pkg::rnd_words_t rnd
);

    // x^64 + x^63 + x^61 + x^60 + 1, right-shifting Galois form
    localparam logic [63:0] TAPS = 64'hd800_0000_0000_0000;

    logic [63:0] lfsr;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[63:1]} ^ (lfsr[0] ? TAPS : 64'd0);
        end
    end

    // fold each 12-bit slice below q, slightly biased
    always_comb begin
        ntt_pwm_pkg::coeff_t slice;
        for (int i = 0; i < ntt_pwm_pkg::RND_WORDS; i++) begin
            slice = lfsr[i*ntt_pwm_pkg::COEFF_W +: ntt_pwm_pkg::COEFF_W];
            rnd[i] = (slice >= ntt_pwm_pkg::MLKEM_Q) ? slice - ntt_pwm_pkg::MLKEM_Q : slice;
        end
    end

endmodule

`default_nettype wire

// ==== source/delay_line.sv ====
/*
 * fixed-depth shift register for any packed payload
 */
`timescale 1ns/1ns
`default_nettype none

module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     zeroize,
    input  payload_t d,
    output payload_t q
);

    payload_t pipe [DEPTH];

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // oldest entry, DEPTH edges after it was sampled
    assign q = pipe[DEPTH-1];

endmodule

`default_nettype wire

// ==== source/masked_add.sv ====
/*
 * share-wise adder modulo q with one register stage
 */
`timescale 1ns/1ns
`default_nettype none

module masked_add (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  ntt_pwm_pkg::masked_coeff_t x,
    input  ntt_pwm_pkg::masked_coeff_t y,
    output ntt_pwm_pkg::masked_coeff_t s
);

    logic [ntt_pwm_pkg::COEFF_W:0] raw [2];
    logic [ntt_pwm_pkg::COEFF_W:0] fold [2];

    // each share sum stays below 2q, one subtraction is enough
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            raw[i] = {1'b0, x[i]} + {1'b0, y[i]};
            fold[i] = (raw[i] >= {1'b0, ntt_pwm_pkg::MLKEM_Q}) ?
                      raw[i] - {1'b0, ntt_pwm_pkg::MLKEM_Q} : raw[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            s <= '0;
        end else begin
            s[0] <= fold[0][ntt_pwm_pkg::COEFF_W-1:0];
            s[1] <= fold[1][ntt_pwm_pkg::COEFF_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/masked_mult.sv ====
/*
 * two-share multiplier modulo q, cross terms hidden by one refresh word
 */
`timescale 1ns/1ns
`default_nettype none

module masked_mult (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  ntt_pwm_pkg::masked_coeff_t x,
    input  ntt_pwm_pkg::masked_coeff_t y,
    input  ntt_pwm_pkg::coeff_t        r,
    output ntt_pwm_pkg::masked_coeff_t z
);

    localparam int PW = 2 * ntt_pwm_pkg::COEFF_W;
    localparam int SW = ntt_pwm_pkg::PROD_W;

    // share products, each below q^2
    logic [PW-1:0] p00;
    logic [PW-1:0] p01;
    logic [PW-1:0] p10;
    logic [PW-1:0] p11;

    // refreshed sums before reduction
    logic [SW-1:0] sum0;
    logic [SW-1:0] sum1;

    ntt_pwm_pkg::coeff_t r_neg;

    // r is below q, so q - r lands in 1 .. q
    assign r_neg = ntt_pwm_pkg::MLKEM_Q - r;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            p00 <= '0;
            p01 <= '0;
            p10 <= '0;
            p11 <= '0;
            sum0 <= '0;
            sum1 <= '0;
        end else begin
            p00 <= PW'(x[0]) * PW'(y[0]);
            p01 <= PW'(x[0]) * PW'(y[1]);
            p10 <= PW'(x[1]) * PW'(y[0]);
            p11 <= PW'(x[1]) * PW'(y[1]);
            // +r on one side and -r on the other cancel in the share sum
            sum0 <= SW'(p00) + SW'(p01) + SW'(r);
            sum1 <= SW'(p10) + SW'(p11) + SW'(r_neg);
        end
    end

    // --------------------
    // per-share reduction

    mod_q_reduce reduce_s0_i (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (sum0),
        .y       (z[0])
    );

    mod_q_reduce reduce_s1_i (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (sum1),
        .y       (z[1])
    );

endmodule

`default_nettype wire

// ==== source/mod_q_reduce.sv ====
/*
 * two-stage Barrett reduction of one 25-bit value into 0 .. q-1
 */
`timescale 1ns/1ns
`default_nettype none

module mod_q_reduce (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         zeroize,
    input  logic [ntt_pwm_pkg::PROD_W-1:0] x,
    output ntt_pwm_pkg::coeff_t          y
);

    localparam int W = ntt_pwm_pkg::PROD_W;
    localparam int K = ntt_pwm_pkg::BARRETT_K;
    localparam int EW = W + K;
    localparam logic [W-1:0] Q_W = W'(ntt_pwm_pkg::MLKEM_Q);

    logic [EW-1:0] est_prod;
    logic [W-1:0]  quot;
    logic [W-1:0]  x_q;
    logic [W-1:0]  quot_q;
    logic [W-1:0]  rem;
    logic [W-1:0]  rem_fold;

    // stage 1: quotient estimate, low by at most one
    always_comb begin
        est_prod = EW'(x) * EW'(ntt_pwm_pkg::BARRETT_M);
        quot = est_prod[EW-1:K];
    end

    // stage 2: remainder lies in 0 .. 2q-1 before the fold
    always_comb begin
        rem = x_q - quot_q * Q_W;
        rem_fold = (rem >= Q_W) ? rem - Q_W : rem;
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            x_q <= '0;
            quot_q <= '0;
            y <= '0;
        end else begin
            x_q <= x;
            quot_q <= quot;
            y <= rem_fold[ntt_pwm_pkg::COEFF_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/pwm_operand_if.sv ====
/*
 * operand bundle for one pairwise multiply, with its strobes
 */
`timescale 1ns/1ns
`default_nettype none

interface pwm_operand_if;

    // one-cycle strobe, the other fields only matter while it is high
    logic valid;
    logic accumulate;

    ntt_pwm_pkg::masked_coeff_t u0;
    ntt_pwm_pkg::masked_coeff_t u1;
    ntt_pwm_pkg::masked_coeff_t v0;
    ntt_pwm_pkg::masked_coeff_t v1;
    ntt_pwm_pkg::masked_coeff_t w0;
    ntt_pwm_pkg::masked_coeff_t w1;
    ntt_pwm_pkg::masked_coeff_t zeta;

    modport source (output valid, accumulate, u0, u1, v0, v1, w0, w1, zeta);
    modport sink (input valid, accumulate, u0, u1, v0, v1, w0, w1, zeta);

endinterface

`default_nettype wire

// ==== source/ntt_pwm_pkg.sv ====
/*
 * shared constants and types of the masked pairwise-multiply engine
 */
`default_nettype none

package ntt_pwm_pkg;

    // coefficient and share format
    localparam int COEFF_W = 12;
    typedef logic [COEFF_W-1:0] coeff_t;
    // true value is (share 0 + share 1) mod q
    typedef coeff_t [1:0] masked_coeff_t;

    localparam coeff_t MLKEM_Q = 12'd3329;

    // refreshed sum of two share products fits in 25 bits
    localparam int PROD_W = 25;

    // floor(2^26 / q), exact to one subtraction for inputs below 2^25
    localparam int BARRETT_K = 26;
    localparam logic [15:0] BARRETT_M = 16'd20158;

    // --------------------
    // pipeline latencies
    localparam int REDUCE_LAT = 2;
    localparam int MULT_LAT = 2 + REDUCE_LAT;
    localparam int ADD_LAT = 1;
    localparam int PWM_LAT = 2 * MULT_LAT + 2 * ADD_LAT;

    localparam int RND_WORDS = 5;
    typedef coeff_t [RND_WORDS-1:0] rnd_words_t;

endpackage

`default_nettype wire
